// ==== files.f ====
+incdir+common
common/cp0_reg_pkg.sv
common/cp0_exc_pkg.sv
cp0/cp0_regs.sv
cp0/cp0_timer.sv
cp0/cp0_exc_ctrl.sv
cp0/cp0_top.sv
verification/cp0_checker.sv
verification/cp0_tb.sv

// ==== Bender.yml ====
package:
  name: cp0

sources:
  - include_dirs:
      - common
    files:
      - common/cp0_reg_pkg.sv
      - common/cp0_exc_pkg.sv
      - cp0/cp0_regs.sv
      - cp0/cp0_timer.sv
      - cp0/cp0_exc_ctrl.sv
      - cp0/cp0_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/cp0_checker.sv
      - verification/cp0_tb.sv

// ==== verification/cp0_tb.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_tb;

    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    localparam int OP_RD  = 0;  // read only
    localparam int OP_MT  = 1;  // mtc0 write
    localparam int OP_RET = 2;  // retire
    localparam int OP_ER  = 3;  // eret
    localparam int OP_ERB = 4;  // eret held into the flush cycle
    localparam int OP_WT  = 5;  // wait for int_pending

    typedef struct {
        int          op;
        int          sel;      // mtc0 addr or exc code
        logic [31:0] data;     // mtc0 data, retire pc or eret target
        int          rnd;
        int          ds;
        int          exc;
        int          raddr;
        logic [31:0] mask;     // expected rdata = (data & mask) | orv
        logic [31:0] orv;
        int          redir;    // 0 none, 1 vector, 2 eret
        int          pend;     // -1 skips the check
        int          kern;
    } row_t;

    logic        clk;
    logic        rst;
    logic        mtc0_valid;
    mtc0_t       mtc0;
    logic        retire_valid;
    retire_t     retire;
    logic        eret_valid;
    logic [5:0]  hw_int;
    cp0_addr_e   raddr;
    logic [31:0] rdata;
    logic        redirect_valid;
    redirect_t   redirect;
    logic        int_pending;
    logic        kernel_mode;
    row_t        rows[$];
    row_t        r;
    int          n;

    cp0_top i_dut (
        .clk(clk), .rst(rst), .mtc0_valid(mtc0_valid), .mtc0(mtc0),
        .retire_valid(retire_valid), .retire(retire), .eret_valid(eret_valid),
        .hw_int(hw_int), .raddr(raddr), .rdata(rdata), .redirect_valid(redirect_valid),
        .redirect(redirect), .int_pending(int_pending), .kernel_mode(kernel_mode)
    );

    always #5 clk = ~clk;

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add(int op, int sel, logic [31:0] data, int rnd, int ds, int exc,
                       int ra, logic [31:0] mask, logic [31:0] orv, int redir,
                       int pend, int kern);
        row_t t;
        t = '{op, sel, data, rnd, ds, exc, ra, mask, orv, redir, pend, kern};
        rows.push_back(t);
    endtask

    task automatic fill_table();
        // reset and constant values of every register but the running Count
        add(OP_RD, 0, 0, 0, 0, 0, 8, 0, 0, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 11, 0, 0, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 12, 0, 32'h0040_ff02, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 13, 0, 0, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 14, 0, 0, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 15, 0, `CP0_PRID_VALUE, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 16, 0, `CP0_CONFIG_VALUE, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 3, 0, 32'hffff_ffff, 0, 0, 1);
        // masked random writes
        add(OP_MT, 12, 0, 1, 0, 0, 12, 32'h0000_ff03, 32'h0040_0000, 0, -1, -1);
        add(OP_MT, 13, 0, 1, 0, 0, 13, 32'h0000_0300, 0, 0, -1, -1);
        add(OP_MT, 14, 0, 1, 0, 0, 14, 32'hffff_ffff, 0, 0, -1, -1);
        add(OP_MT, 15, 0, 1, 0, 0, 15, 0, `CP0_PRID_VALUE, 0, -1, -1);
        add(OP_MT, 13, 0, 0, 0, 0, 13, 0, 0, 0, 0, -1);
        add(OP_MT, 12, 0, 0, 0, 0, 12, 0, 32'h0040_0000, 0, 0, 0);
        // entry, nested entry, eret with a dropped second strobe
        add(OP_RET, 4, 32'h1000, 0, 0, 1, 8, 0, 32'hffff_efff, 1, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 14, 0, 32'h1000, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 13, 0, 32'h10, 0, 0, 1);
        add(OP_RET, 8, 32'h2000, 0, 1, 1, 14, 0, 32'h1000, 1, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 13, 0, 32'h20, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 8, 0, 32'hffff_efff, 0, 0, 1);
        add(OP_ERB, 0, 32'h1000, 0, 0, 0, 12, 0, 32'h0040_0000, 2, 0, 0);
        add(OP_RET, 12, 32'h3008, 0, 1, 1, 13, 0, 32'h8000_0030, 1, 0, 1); // delay slot
        add(OP_RD, 0, 0, 0, 0, 0, 14, 0, 32'h3004, 0, 0, 1);
        add(OP_ER, 0, 32'h3004, 0, 0, 0, 12, 0, 32'h0040_0000, 2, 0, 0);
        add(OP_RET, 9, 0, 1, 0, 1, 14, 32'hffff_ffff, 0, 1, 0, 1);
        add(OP_MT, 12, 0, 0, 0, 0, 12, 0, 32'h0040_0000, 0, 0, 0);
        // masking of a software interrupt
        add(OP_MT, 13, 32'h100, 0, 0, 0, 13, 0, 32'h124, 0, 0, 0);
        add(OP_MT, 12, 32'h101, 0, 0, 0, 12, 0, 32'h0040_0101, 0, 1, 0);
        add(OP_RET, 0, 32'h4000, 0, 0, 0, 12, 0, 32'h0040_0103, 1, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 14, 0, 32'h4000, 0, 0, 1);
        add(OP_RD, 0, 0, 0, 0, 0, 13, 0, 32'h100, 0, 0, 1);
        add(OP_MT, 12, 32'h001, 0, 0, 0, 12, 0, 32'h0040_0001, 0, 0, 0);  // IM off
        add(OP_RET, 0, 32'h4100, 0, 0, 0, 14, 0, 32'h4000, 0, 0, 0);
        add(OP_MT, 12, 32'h100, 0, 0, 0, 12, 0, 32'h0040_0100, 0, 0, 0);  // IE off
        add(OP_RET, 0, 32'h4200, 0, 0, 0, 14, 0, 32'h4000, 0, 0, 0);
        add(OP_MT, 12, 32'h103, 0, 0, 0, 12, 0, 32'h0040_0103, 0, 0, 1);  // EXL on
        add(OP_RET, 0, 32'h4300, 0, 0, 0, 14, 0, 32'h4000, 0, 0, 1);
        add(OP_MT, 13, 0, 0, 0, 0, 13, 0, 0, 0, 0, 1);
        // timer through IP7
        add(OP_MT, 12, 32'h8001, 0, 0, 0, 12, 0, 32'h0040_8001, 0, 0, 0);
        add(OP_MT, 9, 0, 0, 0, 0, 13, 0, 0, 0, 0, 0);
        add(OP_MT, 11, 8, 0, 0, 0, 11, 0, 8, 0, 0, 0);
        add(OP_WT, 0, 0, 0, 0, 0, 13, 32'hc000_8000, 32'h4000_8000, 0, 1, 0);
        add(OP_MT, 11, 32'h1000, 0, 0, 0, 13, 0, 0, 0, 0, 0);       // ack clears TI
    endtask

    task automatic wait_timer_int();
        int cyc;
        cyc = 0;
        while (!int_pending) begin
            @(negedge clk);
            cyc++;
            if (cyc > 200) begin
                $display("timer interrupt never became pending");
                $display("Test failed");
                $fatal(1, "timeout");
            end
        end
    endtask

    task automatic apply_row(row_t t);
        if (t.rnd != 0)
            t.data = $urandom;
        @(posedge clk);
        mtc0_valid        <= (t.op == OP_MT);
        mtc0.addr         <= cp0_addr_e'(t.sel[4:0]);
        mtc0.data.raw     <= t.data;
        retire_valid      <= (t.op == OP_RET);
        retire.pc         <= t.data;
        retire.delay_slot <= t.ds[0];
        retire.exc        <= t.exc[0];
        retire.code       <= exc_code_e'(t.sel[4:0]);
        retire.badvaddr   <= ~t.data;   // distinct from pc
        eret_valid        <= (t.op == OP_ER || t.op == OP_ERB);
        raddr             <= cp0_addr_e'(t.raddr[4:0]);
        if (t.op == OP_WT) begin
            @(negedge clk);
            wait_timer_int();
            check_value("rdata", rdata & t.mask, t.orv);
            check_value("kernel_mode", kernel_mode, t.kern);
            return;
        end
        @(posedge clk);  // strobe sampled here
        mtc0_valid   <= 1'b0;
        retire_valid <= 1'b0;
        if (t.op != OP_ERB)
            eret_valid <= 1'b0;
        @(negedge clk);
        check_value("redirect_valid", redirect_valid, t.redir != 0);
        if (t.redir == 1)
            check_value("redirect.target", redirect.target, `CP0_EXC_VECTOR);
        if (t.redir == 2)
            check_value("redirect.target", redirect.target, t.data);
        if (t.redir != 0)
            check_value("redirect.is_eret", redirect.is_eret, t.redir == 2);
        @(posedge clk);  // update lands here
        eret_valid <= 1'b0;
        @(negedge clk);
        if (t.op == OP_ERB)
            check_value("redirect_valid", redirect_valid, 0);  // second eret dropped
        check_value("rdata", rdata, (t.data & t.mask) | t.orv);
        if (t.pend >= 0)
            check_value("int_pending", int_pending, t.pend);
        if (t.kern >= 0)
            check_value("kernel_mode", kernel_mode, t.kern);
    endtask

    // whole-run watchdog
    initial begin
        #200us;
        $display("simulation ran out of time");
        $display("Test failed");
        $fatal(1, "watchdog");
    end

    initial begin
        void'($urandom(32'hcd1e));
        clk          = 1'b0;
        rst          = 1'b1;
        mtc0_valid   = 1'b0;
        mtc0         = '0;
        retire_valid = 1'b0;
        retire       = '0;
        eret_valid   = 1'b0;
        hw_int       = 6'd0;
        raddr        = CP0_STATUS;
        fill_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (n = 0; n < rows.size(); n++) begin
            r = rows[n];
            apply_row(r);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== verification/cp0_checker.sv ====
`timescale 1ns/1ps

module cp0_checker (
    input logic clk,
    input logic rst,
    input logic accept,
    input logic redirect_valid,
    input logic is_eret,
    input logic exl
);

    // accepted strobe shows up as a redirect on the next cycle
    redirect_follows_accept: assert property (
        @(posedge clk) disable iff (rst) accept |=> redirect_valid
    ) else $error("redirect missing after an accepted strobe");

    // one flush cycle only
    redirect_single_cycle: assert property (
        @(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid
    ) else $error("redirect held for two cycles");

    // entry leaves kernel mode on
    entry_sets_exl: assert property (
        @(posedge clk) disable iff (rst) (redirect_valid && !is_eret) |=> exl
    ) else $error("EXL clear after exception entry");

    redirect_has_cause: assert property (
        @(posedge clk) disable iff (rst) redirect_valid |-> $past(accept)
    ) else $error("redirect without an accepted strobe");

endmodule

bind cp0_exc_ctrl cp0_checker i_checker (
    .clk            (clk),
    .rst            (rst),
    .accept         (accept),
    .redirect_valid (redirect_valid),
    .is_eret        (redirect.is_eret),
    .exl            (exl)
);

// ==== cp0/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mtc0_valid,
    input  cp0_reg_pkg::mtc0_t      mtc0,
    input  logic                    retire_valid,
    input  cp0_exc_pkg::retire_t    retire,
    input  logic                    eret_valid,
    input  logic [5:0]              hw_int,
    input  cp0_reg_pkg::cp0_addr_e  raddr,
    output logic [31:0]             rdata,
    output logic                    redirect_valid,
    output cp0_exc_pkg::redirect_t  redirect,
    output logic                    int_pending,
    output logic                    kernel_mode
);

    import cp0_exc_pkg::*;

    logic        exl;
    logic [31:0] epc;
    logic        update_valid;
    exc_update_t update;   // fsm -> reg file
    logic        count_wr;
    logic        compare_wr;
    logic [31:0] timer_wdata;
    logic [31:0] count;
    logic [31:0] compare;
    logic        timer_int;

    cp0_regs i_regs (
        .clk          (clk),
        .rst          (rst),
        .mtc0_valid   (mtc0_valid),
        .mtc0         (mtc0),
        .raddr        (raddr),
        .hw_int       (hw_int),
        .update_valid (update_valid),
        .update       (update),
        .count        (count),
        .compare      (compare),
        .timer_int    (timer_int),
        .rdata        (rdata),
        .int_pending  (int_pending),
        .exl          (exl),
        .epc          (epc),
        .kernel_mode  (kernel_mode),
        .count_wr     (count_wr),
        .compare_wr   (compare_wr),
        .timer_wdata  (timer_wdata)
    );

    cp0_timer i_timer (
        .clk         (clk),
        .rst         (rst),
        .count_wr    (count_wr),
        .compare_wr  (compare_wr),
        .timer_wdata (timer_wdata),
        .count       (count),
        .compare     (compare),
        .timer_int   (timer_int)
    );

    cp0_exc_ctrl i_exc_ctrl (
        .clk            (clk),
        .rst            (rst),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .eret_valid     (eret_valid),
        .int_pending    (int_pending),
        .exl            (exl),
        .epc            (epc),
        .update_valid   (update_valid),
        .update         (update),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

endmodule

// ==== cp0/cp0_exc_ctrl.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_exc_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      retire_valid,
    input  cp0_exc_pkg::retire_t      retire,
    input  logic                      eret_valid,
    input  logic                      int_pending,
    input  logic                      exl,
    input  logic [31:0]               epc,
    output logic                      update_valid,
    output cp0_exc_pkg::exc_update_t  update,
    output logic                      redirect_valid,
    output cp0_exc_pkg::redirect_t    redirect
);

    import cp0_exc_pkg::*;

    exc_state_e  state;
    logic        take_exc;
    logic        take_int;
    logic        take_eret;
    logic        accept;
    exc_update_t update_d;
    redirect_t   redirect_d;

    always_comb begin
        take_exc  = retire_valid && retire.exc;
        take_int  = retire_valid && !retire.exc && int_pending;
        take_eret = eret_valid && !(take_exc || take_int);  // retire first
        accept    = (state == RUN) && (take_exc || take_int || take_eret);
    end

    always_comb begin
        update_d                = '0;
        update_d.set_exl        = take_exc || take_int;
        update_d.clr_exl        = take_eret;
        update_d.write_epc      = (take_exc || take_int) && !exl; // no nesting
        update_d.epc            = retire.delay_slot ? retire.pc - 32'd4 : retire.pc;
        update_d.code           = take_exc ? retire.code : INT;
        update_d.bd             = retire.delay_slot;
        update_d.write_badvaddr = take_exc && (retire.code == ADEL || retire.code == ADES);
        update_d.badvaddr       = retire.badvaddr;
        redirect_d.target       = take_eret ? epc : `CP0_EXC_VECTOR;
        redirect_d.is_eret      = take_eret;
    end

    // one flush cycle per accepted event, anything arriving then is lost
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= RUN;
        else if (state == FLUSH)
            state <= RUN;
        else if (accept)
            state <= FLUSH;
    end

    // payload captured on the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            update   <= update_d;
            redirect <= redirect_d;
        end
    end

    // both strobes live for exactly the FLUSH cycle
    assign update_valid   = (state == FLUSH);
    assign redirect_valid = (state == FLUSH);

endmodule

// ==== cp0/cp0_timer.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        count_wr,
    input  logic        compare_wr,
    input  logic [31:0] timer_wdata,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_int
);

    // at least one bit, even for a divide by 1
    localparam int DIV_W = ($clog2(`CP0_COUNT_DIV) > 0) ? $clog2(`CP0_COUNT_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [31:0]      count_inc;

    assign tick      = (div_cnt == DIV_W'(`CP0_COUNT_DIV - 1));
    assign count_inc = count + 32'd1;

    // prescaler
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count     <= 32'd0;
            compare   <= 32'd0;
            timer_int <= 1'b0;
        end else begin
            if (count_wr)
                count <= timer_wdata;  // sw write beats the tick
            else if (tick)
                count <= count_inc;
            if (compare_wr) begin
                compare   <= timer_wdata;
                timer_int <= 1'b0;     // ack
            end else if (tick && !count_wr && count_inc == compare)
                timer_int <= 1'b1;     // sticky until Compare written
        end
    end

endmodule

// ==== cp0/cp0_regs.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mtc0_valid,
    input  cp0_reg_pkg::mtc0_t        mtc0,
    input  cp0_reg_pkg::cp0_addr_e    raddr,
    input  logic [5:0]                hw_int,
    input  logic                      update_valid,
    input  cp0_exc_pkg::exc_update_t  update,
    input  logic [31:0]               count,
    input  logic [31:0]               compare,
    input  logic                      timer_int,
    output logic [31:0]               rdata,
    output logic                      int_pending,
    output logic                      exl,
    output logic [31:0]               epc,
    output logic                      kernel_mode,
    output logic                      count_wr,
    output logic                      compare_wr,
    output logic [31:0]               timer_wdata
);

    import cp0_reg_pkg::*;

    status_t     status_q;
    logic [31:0] badvaddr_q;
    logic [31:0] epc_q;
    logic        cause_bd_q;
    logic [4:0]  cause_code_q;
    logic [1:0]  cause_sw_q;    // software IP1:0
    cause_t      cause_view;    // assembled Cause for reads and masking
    logic        mtc0_we;

    // a flush update owns the cycle, the colliding mtc0 is squashed with the pipe
    assign mtc0_we = mtc0_valid && !update_valid;

    assign count_wr    = mtc0_we && (mtc0.addr == CP0_COUNT);
    assign compare_wr  = mtc0_we && (mtc0.addr == CP0_COMPARE);
    assign timer_wdata = mtc0.data.raw;

    always_comb begin
        cause_view          = '0;
        cause_view.bd       = cause_bd_q;
        cause_view.ti       = timer_int;
        cause_view.ip[7]    = hw_int[5] | timer_int; // timer shares line 5
        cause_view.ip[6:2]  = hw_int[4:0];
        cause_view.ip[1:0]  = cause_sw_q;
        cause_view.exc_code = cause_code_q;
    end

    // Status, only IM/EXL/IE are writable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_q     <= '0;
            status_q.bev <= 1'b1;
            status_q.im  <= 8'hff;
            status_q.exl <= 1'b1;   // come up in kernel mode
        end else if (update_valid) begin
            if (update.set_exl)
                status_q.exl <= 1'b1;
            else if (update.clr_exl)
                status_q.exl <= 1'b0;  // eret
        end else if (mtc0_we && mtc0.addr == CP0_STATUS) begin
            status_q.im  <= mtc0.data.status.im;
            status_q.exl <= mtc0.data.status.exl;
            status_q.ie  <= mtc0.data.status.ie;
        end
    end

    // Cause, software only touches IP1:0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause_bd_q   <= 1'b0;
            cause_code_q <= 5'd0;
            cause_sw_q   <= 2'b00;
        end else if (update_valid) begin
            if (update.set_exl)
                cause_code_q <= update.code;
            if (update.write_epc)
                cause_bd_q <= update.bd; // BD follows EPC
        end else if (mtc0_we && mtc0.addr == CP0_CAUSE) begin
            cause_sw_q <= mtc0.data.cause.ip[1:0];
        end
    end

    // EPC takes the full word from mtc0
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            epc_q <= 32'd0;
        else if (update_valid) begin
            if (update.write_epc)
                epc_q <= update.epc;
        end else if (mtc0_we && mtc0.addr == CP0_EPC)
            epc_q <= mtc0.data.raw;
    end

    // BadVAddr, hardware only
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            badvaddr_q <= 32'd0;
        else if (update_valid && update.write_badvaddr)
            badvaddr_q <= update.badvaddr;
    end

    assign exl         = status_q.exl;
    assign kernel_mode = status_q.exl;
    assign epc         = epc_q;
    assign int_pending = status_q.ie && !status_q.exl
                         && |(status_q.im & cause_view.ip);

    always_comb begin
        case (raddr)
            CP0_BADVADDR: rdata = badvaddr_q;
            CP0_COUNT:    rdata = count;
            CP0_COMPARE:  rdata = compare;
            CP0_STATUS:   rdata = status_q;
            CP0_CAUSE:    rdata = cause_view;
            CP0_EPC:      rdata = epc_q;
            CP0_PRID:     rdata = `CP0_PRID_VALUE;
            CP0_CONFIG:   rdata = `CP0_CONFIG_VALUE;
            default:      rdata = 32'hffff_ffff; // unimplemented
        endcase
    end

endmodule

// ==== common/cp0_exc_pkg.sv ====
package cp0_exc_pkg;

    // ExcCode field values
    typedef enum logic [4:0] {
        INT  = 5'd0,   // interrupt
        ADEL = 5'd4,   // addr error on load/fetch
        ADES = 5'd5,   // addr error on store
        SYS  = 5'd8,   // syscall
        BP   = 5'd9,   // breakpoint
        RI   = 5'd10,  // reserved instr
        OV   = 5'd12   // overflow
    } exc_code_e;

    // instruction leaving the pipeline
    typedef struct packed {
        logic [31:0] pc;
        logic        delay_slot;  // sits behind a branch
        logic        exc;         // raised an exception
        exc_code_e   code;
        logic [31:0] badvaddr;    // faulting address, ADEL/ADES only
    } retire_t;

    // fetch redirect to the pipeline
    typedef struct packed {
        logic [31:0] target;
        logic        is_eret;
    } redirect_t;

    typedef enum logic {
        RUN,
        FLUSH
    } exc_state_e;

    // register side effects of an entry or return
    typedef struct packed {
        logic        set_exl;
        logic        clr_exl;
        logic        write_epc;     // also writes BD
        logic [31:0] epc;
        exc_code_e   code;
        logic        bd;
        logic        write_badvaddr;
        logic [31:0] badvaddr;
    } exc_update_t;

endpackage

// ==== common/cp0_reg_pkg.sv ====
package cp0_reg_pkg;

    // implemented register numbers, anything else reads all ones
    typedef enum logic [4:0] {
        CP0_BADVADDR = 5'd8,
        CP0_COUNT    = 5'd9,
        CP0_COMPARE  = 5'd11,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14,
        CP0_PRID     = 5'd15,
        CP0_CONFIG   = 5'd16
    } cp0_addr_e;

    // Status, reg 12
    typedef struct packed {
        logic [8:0] zero_hi;   // 31:23
        logic       bev;       // 22, read-only 1
        logic [5:0] zero_mid;  // 21:16
        logic [7:0] im;        // 15:8 interrupt mask
        logic [5:0] zero_lo;   // 7:2
        logic       exl;       // 1, exception level
        logic       ie;        // 0, global enable
    } status_t;

    // Cause, reg 13
    typedef struct packed {
        logic        bd;       // 31 branch delay
        logic        ti;       // 30 timer pending
        logic [13:0] zero_hi;  // 29:16
        logic [7:0]  ip;       // 15:8, ip7 shared by hw line 5 and timer
        logic        zero_mid; // 7
        logic [4:0]  exc_code; // 6:2
        logic [1:0]  zero_lo;  // 1:0
    } cause_t;

    // one mtc0 data word, seen raw or through a register layout
    typedef union packed {
        logic [31:0] raw;
        status_t     status;
        cause_t      cause;
    } cp0_wdata_u;

    // move-to-coprocessor write
    typedef struct packed {
        cp0_addr_e  addr;
        cp0_wdata_u data;
    } mtc0_t;

endpackage

// ==== common/cp0_cfg.svh ====
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// every exception and interrupt lands here
// BEV is tied to 1, so this is the bootstrap general vector
`define CP0_EXC_VECTOR 32'hbfc0_0380

// processor id, company 0x00, impl 0x42, rev 0x20
`define CP0_PRID_VALUE 32'h0000_4220

// bit 15 set for big endian
// all other fields read as 0
`define CP0_CONFIG_VALUE 32'h0000_8000

// clocks per Count tick
// Count runs at half the core clock
`define CP0_COUNT_DIV 2

`endif
